/* common/cia_defs.svh */
// register map and widths of the peripheral
// included by the package and by every module that sizes ports or decodes
`ifndef CIA_DEFS_SVH
`define CIA_DEFS_SVH

//----------------------------------------
// bus widths
//----------------------------------------
`define CIA_ADDR_W  3            // byte register address
`define CIA_DATA_W  8            // byte data path

//----------------------------------------
// register addresses
//----------------------------------------
`define CIA_TA_LO   3'd0         // timer A count / latch low
`define CIA_TA_HI   3'd1         // timer A count / latch high
`define CIA_CRA     3'd2         // control register A
`define CIA_TOD_LO  3'd3         // time of day low byte
`define CIA_TOD_MID 3'd4         // time of day mid byte
`define CIA_TOD_HI  3'd5         // time of day high byte
`define CIA_CRB     3'd6         // control register B, bit 7 only
`define CIA_ICR     3'd7         // interrupt control

`define CIA_TOD_W   24           // time of day counter
`define CIA_TA_W    16           // interval timer

`endif

/* common/cia_pkg.sv */
// shared types of the peripheral: the broadcast register request,
// the one-hot register select and the interrupt event pulses
`include "cia_defs.svh"

package cia_pkg;

  //----------------------------------------
  // register request from the APB slave
  //----------------------------------------
  typedef struct packed {
    logic                   wr;     // one cycle write strobe
    logic                   rd;     // one cycle read strobe
    logic [`CIA_ADDR_W-1:0] addr;   // byte register
    logic [`CIA_DATA_W-1:0] wdata;  // write byte
  } bus_req_t;

  // one bit per register, decoded from the address
  typedef struct packed {
    logic icr;
    logic crb;
    logic tod_hi;
    logic tod_mid;
    logic tod_lo;
    logic cra;
    logic ta_hi;
    logic ta_lo;
  } reg_sel_t;

  // event pulses into the interrupt controller
  typedef struct packed {
    logic tod_alarm;  // flag bit 1
    logic ta_under;   // flag bit 0
  } irq_src_t;

  // address to one-hot select
  function automatic reg_sel_t decode_sel(input logic [`CIA_ADDR_W-1:0] addr);
    reg_sel_t sel;
    sel         = '0;
    sel.ta_lo   = (addr == `CIA_TA_LO);
    sel.ta_hi   = (addr == `CIA_TA_HI);
    sel.cra     = (addr == `CIA_CRA);
    sel.tod_lo  = (addr == `CIA_TOD_LO);
    sel.tod_mid = (addr == `CIA_TOD_MID);
    sel.tod_hi  = (addr == `CIA_TOD_HI);
    sel.crb     = (addr == `CIA_CRB);
    sel.icr     = (addr == `CIA_ICR);
    return sel;
  endfunction

endpackage

/* src/apb_regif.sv */
// APB slave front end: turns each transfer into one register strobe
// and returns the ORed block read data with pready in the second access cycle
`include "cia_defs.svh"

module apb_regif import cia_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`CIA_ADDR_W-1:0] paddr,
  input  logic [`CIA_DATA_W-1:0] pwdata,
  input  logic [`CIA_DATA_W-1:0] tod_rdata,  // time of day block
  input  logic [`CIA_DATA_W-1:0] ta_rdata,   // interval timer block
  input  logic [`CIA_DATA_W-1:0] irq_rdata,  // interrupt block
  output logic [`CIA_DATA_W-1:0] prdata,
  output logic                   pready,
  output logic                   pslverr,
  output bus_req_t               req
);

  typedef enum logic [1:0] {
    st_idle,    // waiting for psel and penable
    st_access,  // pready cycle
    st_done     // wait for penable to drop
  } state_t;

  state_t state;
  state_t state_nxt;
  logic   start;                         // first access cycle
  logic [`CIA_DATA_W-1:0] rdata_or;      // blocks return 0 when not addressed

  assign start    = (state == st_idle) && psel && penable;
  assign rdata_or = tod_rdata | ta_rdata | irq_rdata;

  //----------------------------------------
  // request broadcast
  //----------------------------------------
  assign req.wr    = start & pwrite;   // single strobe per transfer
  assign req.rd    = start & ~pwrite;
  assign req.addr  = paddr;
  assign req.wdata = pwdata;

  // next state
  always_comb begin
    state_nxt = state;
    case (state)
      st_idle:   if (start) state_nxt = st_access;
      st_access: state_nxt = st_done;
      st_done:   if (!penable) state_nxt = st_idle;  // held transfer ends here
      default:   state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // read byte captured in the first access cycle
  always_ff @(posedge clk) begin
    if (req.rd) begin
      prdata <= rdata_or;
    end
  end

  assign pready  = (state == st_access);  // exactly one cycle
  assign pslverr = 1'b0;                  // all eight addresses exist

endmodule

/* tod/tod_counter.sv */
// time of day counter: 24 bit tick counter with read latch, write stop,
// alarm compare and the alarm select bit of control register B
`include "cia_defs.svh"

module tod_counter import cia_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  bus_req_t               req,
  input  logic                   tod_tick,   // one cycle count pulse
  output logic [`CIA_DATA_W-1:0] rdata,
  output logic                   alarm_evt
);

  reg_sel_t              sel;
  logic                  tod_sel;        // any of the three count bytes
  logic                  tod_wr;         // write to the count
  logic                  alarm_wr;       // write to the alarm
  logic                  tod_inc;        // count advances this edge
  logic                  latch_ena;      // 0 while a byte read is in progress
  logic                  count_ena;      // 0 after a high or mid write
  logic                  crb7;           // 1 = writes go to the alarm
  logic                  count_del;      // increment happened last edge
  logic [`CIA_TOD_W-1:0] tod;
  logic [`CIA_TOD_W-1:0] alarm;
  logic [`CIA_TOD_W-1:0] tod_latch;
  logic [`CIA_TOD_W-1:0] tod_view;       // value seen by reads

  assign sel      = decode_sel(req.addr);
  assign tod_sel  = sel.tod_lo | sel.tod_mid | sel.tod_hi;
  assign tod_wr   = req.wr & ~crb7 & tod_sel;
  assign alarm_wr = req.wr & crb7 & tod_sel;
  assign tod_inc  = tod_tick & count_ena & ~tod_wr;  // a write wins over a tick

  //----------------------------------------
  // read latch
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      latch_ena <= 1'b1;
    end else if (req.rd && sel.tod_hi) begin
      latch_ena <= 1'b0;            // hold for mid and low
    end else if (req.rd && sel.tod_lo) begin
      latch_ena <= 1'b1;            // low byte ends the sequence
    end
  end

  always_ff @(posedge clk) begin
    if (latch_ena) begin
      tod_latch <= tod;
    end
  end

  // live count while the latch is open, so the high byte matches the frozen value
  assign tod_view = latch_ena ? tod : tod_latch;

  always_comb begin
    rdata = '0;
    if (sel.tod_hi)  rdata = tod_view[23:16];
    if (sel.tod_mid) rdata = tod_view[15:8];
    if (sel.tod_lo)  rdata = tod_view[7:0];
    if (sel.crb)     rdata = {crb7, 7'b000_0000};  // bit 7 only
  end

  //----------------------------------------
  // count, stop and restart
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      count_ena <= 1'b1;
    end else if (tod_wr) begin
      if (sel.tod_hi || sel.tod_mid) begin
        count_ena <= 1'b0;          // stopped until low byte
      end else begin
        count_ena <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      tod <= '0;
    end else if (tod_wr) begin
      if (sel.tod_lo)  tod[7:0]   <= req.wdata;
      if (sel.tod_mid) tod[15:8]  <= req.wdata;
      if (sel.tod_hi)  tod[23:16] <= req.wdata;
    end else if (tod_inc) begin
      tod <= tod + 1'b1;
    end
  end

  //----------------------------------------
  // alarm
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      alarm <= '1;                  // never matches a fresh count
    end else if (alarm_wr) begin
      if (sel.tod_lo)  alarm[7:0]   <= req.wdata;
      if (sel.tod_mid) alarm[15:8]  <= req.wdata;
      if (sel.tod_hi)  alarm[23:16] <= req.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      crb7      <= 1'b0;
      count_del <= 1'b0;
    end else begin
      if (req.wr && sel.crb) crb7 <= req.wdata[7];
      count_del <= tod_inc;
    end
  end

  // compare only right after an increment, not after a write
  assign alarm_evt = count_del && (tod == alarm);

endmodule

/* timer/interval_timer.sv */
// interval timer: 16 bit down counter on clk with reload latch,
// one-shot or continuous mode and an underflow event pulse
`include "cia_defs.svh"

module interval_timer import cia_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  bus_req_t               req,
  output logic [`CIA_DATA_W-1:0] rdata,
  output logic                   under_evt   // one cycle per underflow
);

  reg_sel_t             sel;
  logic                 start;      // CRA bit 0
  logic                 oneshot;    // CRA bit 3
  logic                 cra_wr;
  logic                 force_load; // CRA bit 4, not stored
  logic                 underflow;  // count leaves 0 this edge
  logic [`CIA_TA_W-1:0] ta_latch;
  logic [`CIA_TA_W-1:0] ta_count;

  assign sel        = decode_sel(req.addr);
  assign cra_wr     = req.wr & sel.cra;
  assign force_load = cra_wr & req.wdata[4];
  assign underflow  = start && (ta_count == '0);

  //----------------------------------------
  // reload latch
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      ta_latch <= '1;
    end else if (req.wr) begin
      if (sel.ta_lo) ta_latch[7:0]  <= req.wdata;
      if (sel.ta_hi) ta_latch[15:8] <= req.wdata;
    end
  end

  //----------------------------------------
  // control register A
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      start   <= 1'b0;
      oneshot <= 1'b0;
    end else if (cra_wr) begin
      start   <= req.wdata[0];
      oneshot <= req.wdata[3];
    end else if (underflow && oneshot) begin
      start <= 1'b0;                // one-shot stops itself
    end
  end

  //----------------------------------------
  // down counter
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      ta_count <= '1;
    end else if (force_load) begin
      ta_count <= ta_latch;
    end else if (req.wr && sel.ta_hi && !start) begin
      ta_count <= {req.wdata, ta_latch[7:0]};  // stopped: high byte loads
    end else if (underflow) begin
      ta_count <= ta_latch;         // reload on the same edge
    end else if (start) begin
      ta_count <= ta_count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      under_evt <= 1'b0;
    end else begin
      under_evt <= underflow;
    end
  end

  // live count, control bits read back
  always_comb begin
    rdata = '0;
    if (sel.ta_lo) rdata = ta_count[7:0];
    if (sel.ta_hi) rdata = ta_count[15:8];
    if (sel.cra)   rdata = {4'b0000, oneshot, 2'b00, start};
  end

endmodule

/* src/irq_ctrl.sv */
// interrupt controller: mask register, sticky event flags cleared by
// reading ICR, and a registered irq line
`include "cia_defs.svh"

module irq_ctrl import cia_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  bus_req_t               req,
  input  irq_src_t               src,
  output logic [`CIA_DATA_W-1:0] rdata,
  output logic                   irq
);

  reg_sel_t   sel;
  logic [1:0] mask;       // bit 0 timer, bit 1 alarm
  logic [1:0] flags;
  logic [1:0] evt;
  logic       pending;    // set and unmasked

  assign sel     = decode_sel(req.addr);
  assign evt     = {src.tod_alarm, src.ta_under};
  assign pending = |(flags & mask);

  always_ff @(posedge clk) begin
    if (reset) begin
      mask  <= '0;
      flags <= '0;
      irq   <= 1'b0;
    end else begin
      if (req.wr && sel.icr) begin
        if (req.wdata[7]) mask <= mask | req.wdata[1:0];  // set mode
        else              mask <= mask & ~req.wdata[1:0]; // clear mode
      end
      // read clears, a same-cycle event survives
      flags <= ((req.rd && sel.icr) ? 2'b00 : flags) | evt;
      irq   <= pending;
    end
  end

  assign rdata = sel.icr ? {pending, 5'b0_0000, flags} : '0;

endmodule

/* src/cia_top.sv */
// top level of the peripheral: APB slave, time of day counter,
// interval timer and interrupt controller on one broadcast request
`include "cia_defs.svh"

module cia_top import cia_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`CIA_ADDR_W-1:0] paddr,
  input  logic [`CIA_DATA_W-1:0] pwdata,
  output logic [`CIA_DATA_W-1:0] prdata,
  output logic                   pready,
  output logic                   pslverr,
  input  logic                   tod_tick,
  output logic                   irq
);

  bus_req_t               req;        // to all three blocks
  irq_src_t               irq_src;
  logic [`CIA_DATA_W-1:0] tod_rdata;
  logic [`CIA_DATA_W-1:0] ta_rdata;
  logic [`CIA_DATA_W-1:0] irq_rdata;

  apb_regif apb_regif_i (
    .clk       (clk),
    .reset     (reset),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .tod_rdata (tod_rdata),
    .ta_rdata  (ta_rdata),
    .irq_rdata (irq_rdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .req       (req)
  );

  tod_counter tod_counter_i (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .tod_tick  (tod_tick),
    .rdata     (tod_rdata),
    .alarm_evt (irq_src.tod_alarm)
  );

  interval_timer interval_timer_i (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .rdata     (ta_rdata),
    .under_evt (irq_src.ta_under)
  );

  irq_ctrl irq_ctrl_i (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .src       (irq_src),
    .rdata     (irq_rdata),
    .irq       (irq)
  );

endmodule

/* testbench/tb_cia_tasks.svh */
// APB access, check, random and directed test tasks of the peripheral testbench
// included inside the testbench module, uses its signals and counters
`ifndef TB_CIA_TASKS_SVH
`define TB_CIA_TASKS_SVH

//----------------------------------------
// checking and random bytes
//----------------------------------------
task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("error %s: got %h, expected %h", name, got, exp);
  end
endtask

// galois lfsr stepped once per bit
function automatic logic lfsr_bit();
  logic b;
  b    = lfsr[0];
  lfsr = lfsr >> 1;
  if (b) lfsr = lfsr ^ 32'h80200003;   // x^32+x^22+x^2+x+1
  return b;
endfunction

function automatic logic [7:0] rand_byte();
  logic [7:0] v;
  v = 8'h00;
  for (int i = 0; i < 8; i++) begin
    v = {v[6:0], lfsr_bit()};
  end
  return v;
endfunction

//----------------------------------------
// APB transfers
//----------------------------------------
task automatic apb_transfer(input logic write, input logic [`CIA_ADDR_W-1:0] addr,
                            input logic [7:0] wdata, output logic [7:0] rdata);
  int waited;
  waited = 0;
  rdata  = 8'h00;
  @(posedge clk);
  #2;
  psel    = 1'b1;   // setup phase
  penable = 1'b0;
  pwrite  = write;
  paddr   = addr;
  pwdata  = wdata;
  @(posedge clk);
  #2 penable = 1'b1;
  @(negedge clk);
  while (!pready && waited < PREADY_LIMIT) begin
    @(negedge clk);
    waited++;
  end
  if (!pready) begin
    errors++;
    $display("transfer to register %0d got no pready within %0d cycles", addr, PREADY_LIMIT);
  end else begin
    rdata = prdata;
    check("pslverr", 32'(pslverr), 32'd0);
  end
  @(posedge clk);
  #2;
  psel    = 1'b0;
  penable = 1'b0;
  pwrite  = 1'b0;
endtask

task automatic apb_write(input logic [`CIA_ADDR_W-1:0] addr, input logic [7:0] data);
  logic [7:0] unused;
  apb_transfer(1'b1, addr, data, unused);
endtask

task automatic apb_read(input logic [`CIA_ADDR_W-1:0] addr, output logic [7:0] data);
  apb_transfer(1'b0, addr, 8'h00, data);
endtask

task automatic read_check(input string name, input logic [`CIA_ADDR_W-1:0] addr,
                          input logic [7:0] exp);
  logic [7:0] got;
  apb_read(addr, got);
  check(name, 32'(got), 32'(exp));
endtask

//----------------------------------------
// time of day and irq helpers
//----------------------------------------
task automatic tod_read(output logic [23:0] v);
  logic [7:0] hi;
  logic [7:0] mid;
  logic [7:0] lo;
  apb_read(`CIA_TOD_HI, hi);   // freezes the latch
  apb_read(`CIA_TOD_MID, mid);
  apb_read(`CIA_TOD_LO, lo);   // releases it
  v = {hi, mid, lo};
endtask

task automatic tod_check(input string name, input logic [23:0] exp);
  logic [23:0] got;
  tod_read(got);
  check(name, 32'(got), 32'(exp));
endtask

task automatic tod_write(input logic [23:0] v);
  apb_write(`CIA_TOD_HI, v[23:16]);
  apb_write(`CIA_TOD_MID, v[15:8]);
  apb_write(`CIA_TOD_LO, v[7:0]);   // restarts counting
endtask

task automatic alarm_write(input logic [23:0] v);
  apb_write(`CIA_CRB, 8'h80);   // writes go to the alarm
  read_check("prdata CRB", `CIA_CRB, 8'h80);
  tod_write(v);
  apb_write(`CIA_CRB, 8'h00);
endtask

task automatic tick_tod(input int n);
  repeat (n) begin
    @(posedge clk);
    #2 tod_tick = 1'b1;
    @(posedge clk);
    #2 tod_tick = 1'b0;
  end
endtask

task automatic wait_irq(input int limit, input string what);
  int waited;
  waited = 0;
  @(negedge clk);
  while (!irq && waited < limit) begin
    @(negedge clk);
    waited++;
  end
  if (!irq) begin
    errors++;
    $display("irq did not rise for the %s within %0d cycles", what, limit);
  end
endtask

// read ICR until a flag shows up while irq stays low
task automatic poll_icr(input logic [7:0] exp, input string what);
  logic [7:0] val;
  int         tries;
  val   = 8'h00;
  tries = 0;
  while (val == 8'h00 && tries < 10) begin
    apb_read(`CIA_ICR, val);
    check("irq", 32'(irq), 32'd0);
    tries++;
  end
  if (val == 8'h00) begin
    errors++;
    $display("no interrupt flag seen for the %s after %0d reads", what, tries);
  end else begin
    check("prdata ICR", 32'(val), 32'(exp));
  end
endtask

//----------------------------------------
// directed tests
//----------------------------------------
task automatic reset_defaults();
  read_check("prdata TOD_HI", `CIA_TOD_HI, 8'h00);
  read_check("prdata TOD_MID", `CIA_TOD_MID, 8'h00);
  read_check("prdata TOD_LO", `CIA_TOD_LO, 8'h00);
  read_check("prdata TA_LO", `CIA_TA_LO, 8'hff);   // latch and count all ones
  read_check("prdata TA_HI", `CIA_TA_HI, 8'hff);
  read_check("prdata CRB", `CIA_CRB, 8'h00);
  read_check("prdata ICR", `CIA_ICR, 8'h00);
  check("irq", 32'(irq), 32'd0);
endtask

task automatic tod_write_stop();
  logic [23:0] v;
  logic [7:0]  b;
  v[23:16] = rand_byte();
  v[15:8]  = rand_byte();
  v[7:0]   = rand_byte();
  tod_write(v);
  tick_tod(5);
  tod_model = v + 24'd5;
  tod_check("tod after ticks", tod_model);
  b = rand_byte();
  apb_write(`CIA_TOD_HI, b);   // stops the count
  tod_model[23:16] = b;
  tick_tod(4);
  tod_check("tod while stopped", tod_model);
  b = rand_byte();
  apb_write(`CIA_TOD_LO, b);
  tod_model[7:0] = b;
  tick_tod(2);
  tod_model = tod_model + 24'd2;
  tod_check("tod after restart", tod_model);
endtask

task automatic tod_read_latch();
  logic [7:0] hi;
  logic [7:0] mid;
  logic [7:0] lo;
  apb_read(`CIA_TOD_HI, hi);
  tick_tod(3);   // counts on behind the latch
  apb_read(`CIA_TOD_MID, mid);
  apb_read(`CIA_TOD_LO, lo);
  check("tod latched", 32'({hi, mid, lo}), 32'(tod_model));
  tod_model = tod_model + 24'd3;
  tod_check("tod after latch", tod_model);
endtask

task automatic alarm_interrupt();
  logic [7:0] stale;
  apb_read(`CIA_ICR, stale);   // drop flags left from random counts
  alarm_write(tod_model + 24'd3);
  read_check("prdata CRB", `CIA_CRB, 8'h00);
  apb_write(`CIA_ICR, 8'h82);   // unmask alarm
  tick_tod(3);
  tod_model = tod_model + 24'd3;
  wait_irq(8, "alarm");
  read_check("prdata ICR", `CIA_ICR, 8'h82);
  read_check("prdata ICR", `CIA_ICR, 8'h00);   // cleared by the read
  check("irq", 32'(irq), 32'd0);
endtask

task automatic timer_one_shot();
  logic [7:0] latch_val;
  logic [7:0] cra;
  latch_val = 8'd12;
  apb_write(`CIA_ICR, 8'h81);   // unmask timer
  apb_write(`CIA_TA_LO, latch_val);
  apb_write(`CIA_TA_HI, 8'h00);   // stopped, so the count loads too
  read_check("prdata TA_LO", `CIA_TA_LO, latch_val);
  read_check("prdata TA_HI", `CIA_TA_HI, 8'h00);
  apb_write(`CIA_CRA, 8'h09);   // start, one-shot
  wait_irq(int'(latch_val) + 4, "one-shot underflow");
  apb_read(`CIA_CRA, cra);
  check("cra start bit", 32'(cra[0]), 32'd0);
  read_check("prdata TA_LO", `CIA_TA_LO, latch_val);   // reloaded
  read_check("prdata ICR", `CIA_ICR, 8'h81);
endtask

task automatic timer_continuous();
  logic [7:0] latch_val;
  int         period;
  int         window;
  int         window_end;
  int         events;
  latch_val = 8'd30;
  period    = int'(latch_val) + 1;   // count L..0 then reload
  window    = 4 * period + period / 2;
  events    = 0;
  apb_write(`CIA_TA_LO, latch_val);
  apb_write(`CIA_CRA, 8'h11);   // force load, start, continuous
  window_end = cycle_cnt + window;
  while (cycle_cnt < window_end) begin
    @(negedge clk);
    if (irq) begin
      read_check("prdata ICR", `CIA_ICR, 8'h81);
      events++;
    end
  end
  apb_write(`CIA_CRA, 8'h00);
  check("underflow count", 32'(events), 32'(window / period));
  read_check("prdata ICR", `CIA_ICR, 8'h00);
endtask

task automatic irq_masking();
  apb_write(`CIA_ICR, 8'h03);   // clear both masks
  apb_write(`CIA_TA_LO, 8'd6);
  apb_write(`CIA_CRA, 8'h19);   // force load, one-shot, start
  poll_icr(8'h01, "masked timer underflow");
  alarm_write(tod_model + 24'd2);
  tick_tod(2);
  tod_model = tod_model + 24'd2;
  poll_icr(8'h02, "masked alarm");
  check("irq", 32'(irq), 32'd0);
endtask

`endif

/* testbench/tb_cia.sv */
// testbench of the APB peripheral: clock, reset, DUT and the directed test sequence
// the helper and test tasks come from the included task file
`include "cia_defs.svh"

module tb_cia;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int PREADY_LIMIT = 10;   // cycles allowed per transfer

  logic                   clk;
  logic                   reset;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`CIA_ADDR_W-1:0] paddr;
  logic [`CIA_DATA_W-1:0] pwdata;
  logic [`CIA_DATA_W-1:0] prdata;
  logic                   pready;
  logic                   pslverr;
  logic                   tod_tick;
  logic                   irq;

  int                     errors;
  int                     checks;
  int                     cycle_cnt = 0;   // rising edges since start
  logic [31:0]            lfsr;            // random state
  logic [`CIA_TOD_W-1:0]  tod_model;       // expected time of day

  cia_top cia_top_i (
    .clk      (clk),
    .reset    (reset),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .tod_tick (tod_tick),
    .irq      (irq)
  );

  always #20 clk = ~clk;   // 40 ns period

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;   // time base for the timer window
  end

  `include "tb_cia_tasks.svh"

  //----------------------------------------
  // test sequence
  //----------------------------------------
  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    tod_tick  = 1'b0;
    errors    = 0;
    checks    = 0;
    lfsr      = 32'h0133f4e5;
    tod_model = '0;
    repeat (3) @(posedge clk);   // reset for 3 cycles
    #2 reset = 1'b0;

    reset_defaults();
    tod_write_stop();
    tod_read_latch();
    alarm_interrupt();
    timer_one_shot();
    timer_continuous();
    irq_masking();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+common
+incdir+testbench
common/cia_pkg.sv
src/apb_regif.sv
tod/tod_counter.sv
timer/interval_timer.sv
src/irq_ctrl.sv
src/cia_top.sv
testbench/tb_cia.sv

/* Makefile */
# Verilator build and run of the APB peripheral testbench
VERILATOR ?= verilator
TOP       ?= tb_cia
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
